//--- verilog/gat_dims_pkg.sv
package gat_dims_pkg;

  // Feature value and weight width
  parameter int DATA_WIDTH = 8;

  // One WH sum, wraps modulo 2**WH_DATA_WIDTH
  parameter int WH_DATA_WIDTH = 12;

  parameter int NUM_FEATURE_IN  = 16;
  parameter int NUM_FEATURE_OUT = 7;

  // Column index into a row of H
  parameter int COL_IDX_WIDTH = $clog2(NUM_FEATURE_IN);

  // A full row holds NUM_FEATURE_IN entries, so one extra bit
  parameter int ROW_LEN_WIDTH = $clog2(NUM_FEATURE_IN + 1);

  // Node count of a subgraph
  parameter int NUM_NODE_WIDTH = 4;

endpackage

//--- verilog/gat_types_pkg.sv
package gat_types_pkg;

  import gat_dims_pkg::*;

  // One word of the node-info memory
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]  row_len;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      flag;
  } node_info_t;

  // Stored entry of the sparse H matrix
  typedef struct packed {
    logic [DATA_WIDTH-1:0]    value;
    logic [COL_IDX_WIDTH-1:0] col_idx;
  } h_entry_t;

  // Reader to dot product, metadata valid on the last beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0]     value;
    logic [COL_IDX_WIDTH-1:0]  col_idx;
    logic                      row_last;
    logic                      row_empty;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      flag;
  } sparse_beat_t;

  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] sums;
    logic [NUM_NODE_WIDTH-1:0]                     num_node;
    logic                                          flag;
  } wh_word_t;

  // Indexed as [output column][input row]
  typedef logic [NUM_FEATURE_OUT-1:0][NUM_FEATURE_IN-1:0][DATA_WIDTH-1:0] weight_t;

endpackage

//--- verilog/bram.sv
`timescale 1ns/1ns

module bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         din,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
  end

  // Registered read, one cycle after the address
  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else begin
      dout <= mem[raddr];
    end
  end

endmodule

//--- verilog/sparse_row_reader.sv
`timescale 1ns/1ns

module sparse_row_reader
  import gat_dims_pkg::*;
  import gat_types_pkg::*;
#(
  parameter int TOTAL_NODES       = 20,
  parameter int H_NUM_SPARSE_DATA = 140
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 start,
  output logic [$clog2(TOTAL_NODES)-1:0]       node_info_addr,
  input  node_info_t                           node_info,
  output logic [$clog2(H_NUM_SPARSE_DATA)-1:0] h_addr,
  input  h_entry_t                             h_entry,
  output sparse_beat_t                         beat,
  output logic                                 beat_valid
);

  localparam int ROW_W = $clog2(TOTAL_NODES);
  localparam int PTR_W = $clog2(H_NUM_SPARSE_DATA);

  typedef enum logic [1:0] {IDLE, INFO, DATA} state_t;

  state_t                    state;
  logic [ROW_W-1:0]          row_cnt;
  logic [PTR_W-1:0]          data_ptr;
  logic [ROW_LEN_WIDTH-1:0]  remain;
  logic                      first;
  node_info_t                info_q;
  node_info_t                cur_info;
  logic [ROW_LEN_WIDTH-1:0]  cur_remain;
  logic                      issue;
  logic                      issue_last;
  logic                      issue_empty;
  logic                      req_valid;
  logic                      req_last;
  logic                      req_empty;
  logic [NUM_NODE_WIDTH-1:0] req_num_node;
  logic                      req_flag;

  // Node info arrives in the first data cycle of a row
  assign cur_info    = first ? node_info : info_q;
  assign cur_remain  = first ? node_info.row_len : remain;
  assign issue       = (state == DATA);
  assign issue_empty = (cur_info.row_len == '0);
  assign issue_last  = issue_empty || (cur_remain == ROW_LEN_WIDTH'(1));

  assign node_info_addr = row_cnt;
  assign h_addr         = data_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      row_cnt  <= '0;
      data_ptr <= '0;
      remain   <= '0;
      first    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            row_cnt  <= '0;
            data_ptr <= '0;
            state    <= INFO;
          end
        end
        INFO: begin
          first <= 1'b1;
          state <= DATA;
        end
        DATA: begin
          first <= 1'b0;
          if (!issue_empty) begin
            data_ptr <= data_ptr + 1'b1;
            remain   <= cur_remain - 1'b1;
          end
          if (issue_last) begin
            if (row_cnt == ROW_W'(TOTAL_NODES - 1)) begin
              state <= IDLE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              state   <= INFO;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (first) begin
      info_q <= node_info;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid  <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      req_valid  <= issue;
      beat_valid <= req_valid;
    end
  end

  // Metadata waits one cycle for the data memory
  always_ff @(posedge clk) begin
    req_last       <= issue_last;
    req_empty      <= issue_empty;
    req_num_node   <= cur_info.num_node;
    req_flag       <= cur_info.flag;
    beat.value     <= req_empty ? '0 : h_entry.value;
    beat.col_idx   <= h_entry.col_idx;
    beat.row_last  <= req_last;
    beat.row_empty <= req_empty;
    beat.num_node  <= req_num_node;
    beat.flag      <= req_flag;
  end

  assert property (@(posedge clk) disable iff (reset)
    issue && !issue_empty |-> int'(data_ptr) < H_NUM_SPARSE_DATA);

  assert property (@(posedge clk) disable iff (reset)
    start |-> state == IDLE);

endmodule

//--- verilog/wh_dot_product.sv
`timescale 1ns/1ns

module wh_dot_product
  import gat_dims_pkg::*;
  import gat_types_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  weight_t      wgt,
  input  sparse_beat_t beat,
  input  logic         beat_valid,
  output wh_word_t     row,
  output logic         row_valid
);

  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] prod;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] acc;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] acc_next;
  logic                                          p1_valid;
  logic                                          p1_last;
  logic                                          p1_empty;
  logic [NUM_NODE_WIDTH-1:0]                     p1_num_node;
  logic                                          p1_flag;
  logic                                          row_empty;

  // Stage one, one product per output column
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      if (beat.row_empty) begin
        prod[k] <= '0;
      end else begin
        prod[k] <= WH_DATA_WIDTH'(beat.value * wgt[k][beat.col_idx]);
      end
    end
    p1_last     <= beat.row_last;
    p1_empty    <= beat.row_empty;
    p1_num_node <= beat.num_node;
    p1_flag     <= beat.flag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      p1_valid <= 1'b0;
    end else begin
      p1_valid <= beat_valid;
    end
  end

  // Sums wrap at WH_DATA_WIDTH
  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc_next[k] = acc[k] + prod[k];
    end
  end

  // Stage two
  always_ff @(posedge clk) begin
    if (reset) begin
      acc       <= '0;
      row_valid <= 1'b0;
      row_empty <= 1'b0;
    end else begin
      row_valid <= p1_valid && p1_last;
      if (p1_valid) begin
        acc <= p1_last ? '0 : acc_next;
        if (p1_last) begin
          row_empty <= p1_empty;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (p1_valid && p1_last) begin
      row.sums     <= acc_next;
      row.num_node <= p1_num_node;
      row.flag     <= p1_flag;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    row_valid ##1 row_valid |-> row_empty);

endmodule

//--- verilog/wh_writer.sv
`timescale 1ns/1ns

module wh_writer
  import gat_types_pkg::*;
#(
  parameter int TOTAL_NODES = 20
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           spmm_valid,
  output logic                           spmm_ready,
  output logic                           start,
  input  wh_word_t                       row,
  input  logic                           row_valid,
  output logic                           wh_we,
  output logic [$clog2(TOTAL_NODES)-1:0] wh_waddr,
  output wh_word_t                       wh_din
);

  localparam int ADDR_W = $clog2(TOTAL_NODES);

  logic [ADDR_W-1:0] row_cnt;
  logic              accept;

  assign accept = spmm_valid && spmm_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      spmm_ready <= 1'b1;
      start      <= 1'b0;
      wh_we      <= 1'b0;
      row_cnt    <= '0;
    end else begin
      start <= accept;
      wh_we <= row_valid;
      if (row_valid) begin
        row_cnt <= row_cnt + 1'b1;
      end
      if (accept) begin
        spmm_ready <= 1'b0;
        row_cnt    <= '0;
      end else if (wh_we && wh_waddr == ADDR_W'(TOTAL_NODES - 1)) begin
        // Last row is in memory
        spmm_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      wh_waddr <= row_cnt;
      wh_din   <= row;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    row_valid |-> !spmm_ready);

endmodule

//--- verilog/gat_wh.sv
`timescale 1ns/1ns

module gat_wh
  import gat_types_pkg::*;
#(
  parameter int TOTAL_NODES       = 20,
  parameter int H_NUM_SPARSE_DATA = 140
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 spmm_valid,
  output logic                                 spmm_ready,
  input  logic                                 node_info_we,
  input  logic [$clog2(TOTAL_NODES)-1:0]       node_info_addr,
  input  node_info_t                           node_info_din,
  input  logic                                 h_data_we,
  input  logic [$clog2(H_NUM_SPARSE_DATA)-1:0] h_data_addr,
  input  h_entry_t                             h_data_din,
  input  weight_t                              wgt,
  input  logic [$clog2(TOTAL_NODES)-1:0]       wh_addr,
  output wh_word_t                             wh_data
);

  logic [$clog2(TOTAL_NODES)-1:0]       info_raddr;
  node_info_t                           info_dout;
  logic [$clog2(H_NUM_SPARSE_DATA)-1:0] h_raddr;
  h_entry_t                             h_dout;
  sparse_beat_t                         beat;
  logic                                 beat_valid;
  wh_word_t                             row;
  logic                                 row_valid;
  logic                                 start;
  logic                                 wh_we;
  logic [$clog2(TOTAL_NODES)-1:0]       wh_waddr;
  wh_word_t                             wh_din;

  bram #(.WIDTH($bits(node_info_t)), .DEPTH(TOTAL_NODES)) node_info_mem (
    .clk(clk), .reset(reset),
    .we(node_info_we), .waddr(node_info_addr), .din(node_info_din),
    .raddr(info_raddr), .dout(info_dout)
  );

  bram #(.WIDTH($bits(h_entry_t)), .DEPTH(H_NUM_SPARSE_DATA)) h_data_mem (
    .clk(clk), .reset(reset),
    .we(h_data_we), .waddr(h_data_addr), .din(h_data_din),
    .raddr(h_raddr), .dout(h_dout)
  );

  bram #(.WIDTH($bits(wh_word_t)), .DEPTH(TOTAL_NODES)) wh_mem (
    .clk(clk), .reset(reset),
    .we(wh_we), .waddr(wh_waddr), .din(wh_din),
    .raddr(wh_addr), .dout(wh_data)
  );

  sparse_row_reader #(
    .TOTAL_NODES(TOTAL_NODES),
    .H_NUM_SPARSE_DATA(H_NUM_SPARSE_DATA)
  ) reader (
    .clk(clk), .reset(reset), .start(start),
    .node_info_addr(info_raddr), .node_info(info_dout),
    .h_addr(h_raddr), .h_entry(h_dout),
    .beat(beat), .beat_valid(beat_valid)
  );

  wh_dot_product dot_product (
    .clk(clk), .reset(reset), .wgt(wgt),
    .beat(beat), .beat_valid(beat_valid),
    .row(row), .row_valid(row_valid)
  );

  wh_writer #(.TOTAL_NODES(TOTAL_NODES)) writer (
    .clk(clk), .reset(reset),
    .spmm_valid(spmm_valid), .spmm_ready(spmm_ready), .start(start),
    .row(row), .row_valid(row_valid),
    .wh_we(wh_we), .wh_waddr(wh_waddr), .wh_din(wh_din)
  );

  // Input memories are loaded only between runs
  assert property (@(posedge clk) disable iff (reset)
    node_info_we || h_data_we |-> spmm_ready);

endmodule

//--- bench/tb_gat_wh.sv
`timescale 1ns/1ns

module tb_gat_wh
  import gat_dims_pkg::*;
  import gat_types_pkg::*;
();

  localparam int NODES   = 4;
  localparam int DEPTH   = 32;
  localparam int NODE_W  = $clog2(NODES);
  localparam int DEPTH_W = $clog2(DEPTH);
  localparam int TIMEOUT = 200;

  logic              clk;
  logic              reset;
  logic              spmm_valid;
  logic              spmm_ready;
  logic              node_info_we;
  logic [NODE_W-1:0] node_info_addr;
  node_info_t        node_info_din;
  logic              h_data_we;
  logic [DEPTH_W-1:0] h_data_addr;
  h_entry_t          h_data_din;
  weight_t           wgt;
  logic [NODE_W-1:0] wh_addr;
  wh_word_t          wh_data;

  int         w_base[$];
  node_info_t info_list[$];
  h_entry_t   entry_list[$];
  int         col0_list[$];

  gat_wh #(.TOTAL_NODES(NODES), .H_NUM_SPARSE_DATA(DEPTH)) gat_wh_inst (
    .clk(clk), .reset(reset),
    .spmm_valid(spmm_valid), .spmm_ready(spmm_ready),
    .node_info_we(node_info_we), .node_info_addr(node_info_addr),
    .node_info_din(node_info_din),
    .h_data_we(h_data_we), .h_data_addr(h_data_addr), .h_data_din(h_data_din),
    .wgt(wgt), .wh_addr(wh_addr), .wh_data(wh_data)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // Weight pattern over the whole (output column, input row) address
  function automatic logic [DATA_WIDTH-1:0] weight_of(input int base, input int k, input int i);
    return DATA_WIDTH'(base + 31 * k + 7 * i + k * i);
  endfunction

  function automatic int expected_sum(input int base, input int row, input int k);
    int ptr;
    int acc;
    ptr = 0;
    acc = 0;
    for (int r = 0; r < row; r++) begin
      ptr += int'(info_list[r].row_len);
    end
    for (int j = 0; j < int'(info_list[row].row_len); j++) begin
      acc += int'(entry_list[ptr + j].value) *
             int'(weight_of(base, k, int'(entry_list[ptr + j].col_idx)));
    end
    return acc & ((1 << WH_DATA_WIDTH) - 1);
  endfunction

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  tag;
    logic [31:0] val;
    fd = $fopen("bench/wh_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open bench/wh_trace.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%c %h", tag, val) != 2) begin
          abort_run({"Malformed trace line: ", line});
        end
        case (tag)
          "W": w_base.push_back(int'(val));
          "N": info_list.push_back(node_info_t'(val[$bits(node_info_t)-1:0]));
          "H": entry_list.push_back(h_entry_t'(val[$bits(h_entry_t)-1:0]));
          "E": col0_list.push_back(int'(val));
          default: abort_run({"Unknown tag in trace line: ", line});
        endcase
      end
    end
    $fclose(fd);
  endtask

  task automatic load_weights(input int base);
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      for (int i = 0; i < NUM_FEATURE_IN; i++) begin
        wgt[k][i] = weight_of(base, k, i);
      end
    end
  endtask

  task automatic load_memories();
    for (int r = 0; r < NODES; r++) begin
      node_info_we = 1'b1;
      node_info_addr = NODE_W'(r);
      node_info_din = info_list[r];
      @(posedge clk);
      #1;
    end
    node_info_we = 1'b0;
    for (int j = 0; j < entry_list.size(); j++) begin
      h_data_we = 1'b1;
      h_data_addr = DEPTH_W'(j);
      h_data_din = entry_list[j];
      @(posedge clk);
      #1;
    end
    h_data_we = 1'b0;
  endtask

  task automatic wait_ready(input logic level);
    int cycles;
    cycles = 0;
    while (spmm_ready !== level) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("Timed out waiting for spmm_ready to become %0d", level));
      end
    end
  endtask

  task automatic run_once();
    spmm_valid = 1'b1;
    wait_ready(1'b0);
    spmm_valid = 1'b0;
    wait_ready(1'b1);
  endtask

  // Read port has one cycle of latency
  task automatic check_row(input int base, input int row);
    wh_addr = NODE_W'(row);
    @(posedge clk);
    #1;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      check_value($sformatf("wh_data.sums[%0d] of row %0d", k, row),
                  int'(wh_data.sums[k]), expected_sum(base, row, k));
    end
    check_value($sformatf("wh_data.num_node of row %0d", row),
                int'(wh_data.num_node), int'(info_list[row].num_node));
    check_value($sformatf("wh_data.flag of row %0d", row),
                int'(wh_data.flag), int'(info_list[row].flag));
  endtask

  initial begin
    int idle;
    int order[NODES];
    int pick;
    int tmp;
    void'($urandom(38));
    clk = 1'b0;
    reset = 1'b1;
    spmm_valid = 1'b0;
    node_info_we = 1'b0;
    node_info_addr = '0;
    node_info_din = '0;
    h_data_we = 1'b0;
    h_data_addr = '0;
    h_data_din = '0;
    wgt = '0;
    wh_addr = '0;

    read_trace();
    check_value("trace W lines", w_base.size(), 2);
    check_value("trace N lines", info_list.size(), NODES);
    check_value("trace E lines", col0_list.size(), 2 * NODES);
    // Trace column 0 against the sums built from W, N and H
    for (int run = 0; run < 2; run++) begin
      for (int r = 0; r < NODES; r++) begin
        check_value($sformatf("trace column 0 sum of run %0d row %0d", run, r),
                    expected_sum(w_base[run], r, 0), col0_list[run * NODES + r]);
      end
    end

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("spmm_ready", int'(spmm_ready), 1);

    load_memories();
    load_weights(w_base[0]);
    run_once();
    for (int r = 0; r < NODES; r++) begin
      check_row(w_base[0], r);
    end

    idle = $urandom_range(12, 2);
    repeat (idle) @(posedge clk);
    #1;

    // New weights, then rows read back in shuffled order
    load_weights(w_base[1]);
    run_once();
    for (int r = 0; r < NODES; r++) begin
      order[r] = r;
    end
    for (int r = NODES - 1; r > 0; r--) begin
      pick = $urandom_range(r, 0);
      tmp = order[r];
      order[r] = order[pick];
      order[pick] = tmp;
    end
    for (int r = 0; r < NODES; r++) begin
      check_row(w_base[1], order[r]);
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- gat_wh.f
verilog/gat_dims_pkg.sv
verilog/gat_types_pkg.sv
verilog/bram.sv
verilog/sparse_row_reader.sv
verilog/wh_dot_product.sv
verilog/wh_writer.sv
verilog/gat_wh.sv
bench/tb_gat_wh.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_gat_wh -f gat_wh.f -o tb_gat_wh
	./obj_dir/tb_gat_wh

clean:
	rm -rf obj_dir

//--- bench/wh_trace.txt
# Columns: tag, hex value. W weight base of a run, N node info {row_len, num_node, flag},
# H sparse entry {value, col_idx}, E expected column 0 sum per row for run 0 then run 1
W 003
N 049
N 008
N 213
N 03e
H ff3
H 12a
H 8d8
H 9e9
H afa
H c0b
H d1c
H e2d
H f3e
H 04f
H 050
H 161
H 272
H 383
H 494
H 5a5
H 6b6
H 7c7
H 80f
E d0a
E 000
E da8
E 600
W 0c9
E e30
E 000
E b58
E 900
